/* filelist.f */
verilog/qla_pkg.sv
verilog/reg_addr_decode.sv
verilog/axis_ctrl.sv
verilog/board_regs.sv
verilog/reg_read_mux.sv
verilog/qla_ctrl.sv
tb/qla_ctrl_sva.sv
tb/tb_qla_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_qla_ctrl \
    -f filelist.f -o tb_qla_ctrl \
    && ./obj_dir/tb_qla_ctrl \
    || { echo "simulation run failed"; exit 1; }

/* tb/qla_ctrl_sva.sv */
/*
 * Concurrent assertions on the controller top level.
 * Reset state of the amp disables, zero reads outside the main
 * space, and no re-enable of a faulted axis without a status write.
 */

`default_nettype none

module qla_ctrl_sva import qla_pkg::*; #(
    parameter int NUM_AXES = 4
) (
    input logic                sysclk,
    input logic                arst_n,
    input logic                reg_wen,
    input reg_addr_t           reg_waddr,
    input reg_addr_t           reg_raddr,
    input reg_data_t           reg_rdata,
    input logic [NUM_AXES-1:0] amp_disable,
    input logic [NUM_AXES-1:0] safety_fault
);

    logic status_write;     // bus write to chan 0 status

    assign status_write = reg_wen && (reg_waddr[15:12] == ADDR_MAIN)
                          && (reg_waddr[7:4] == 4'd0) && (reg_waddr[3:0] == OFF_STATUS);

    assert property (@(posedge sysclk) !arst_n |-> (&amp_disable))
        else $error("amp_disable not all ones during reset");

    assert property (@(posedge sysclk) disable iff (!arst_n)
        (reg_raddr[15:12] != ADDR_MAIN) |=> (reg_rdata == '0))
        else $error("read outside main space returned nonzero data");

    // re-enable of a held fault needs the status write two cycles back
    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        assert property (@(posedge sysclk) disable iff (!arst_n)
            ($fell(amp_disable[i]) && $past(safety_fault[i])) |-> $past(status_write, 2))
            else $error("axis %0d enabled while its fault was held", i);
    end

endmodule

bind qla_ctrl qla_ctrl_sva #(.NUM_AXES(NUM_AXES)) i_sva (
    .sysclk       (sysclk),
    .arst_n       (arst_n),
    .reg_wen      (reg_wen),
    .reg_waddr    (reg_waddr),
    .reg_raddr    (reg_raddr),
    .reg_rdata    (reg_rdata),
    .amp_disable  (amp_disable),
    .safety_fault (safety_fault)
);

`default_nettype wire

/* tb/tb_qla_ctrl.sv */
/*
 * Directed testbench for the motor-axis controller core.
 * Covers reset state, axis register writes and readback, masked
 * board status writes, the safety trip and fault recovery.
 */

`default_nettype none

module tb_qla_ctrl import qla_pkg::*;;

    localparam int NUM_AXES     = 4;
    localparam int SAFETY_COUNT = 8;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    // cycle budget: reset, axis regs, status, trip and recovery, plus margin
    localparam int RUN_CYCLES   = 2 * (RESET_CYCLES + NUM_AXES * 24 + 60 + 4 * SAFETY_COUNT);

    logic                sysclk;
    logic                arst_n;
    logic                reg_wen;
    reg_addr_t           reg_waddr;
    reg_data_t           reg_wdata;
    reg_addr_t           reg_raddr;
    reg_data_t           reg_rdata;
    field_t              board_id;
    cur_t                cur_fb [NUM_AXES];
    cur_t                cur_cmd [NUM_AXES];
    logic [NUM_AXES-1:0] dout;
    logic [NUM_AXES-1:0] amp_disable;
    logic                pwr_enable;

    // reference state, kept from the register rules
    cur_t                exp_cmd [NUM_AXES];
    logic [NUM_AXES-1:0] exp_dout;
    logic [NUM_AXES-1:0] exp_amp;
    logic [NUM_AXES-1:0] exp_fault;
    logic                exp_pwr;
    int                  seed;

    qla_ctrl #(.NUM_AXES(NUM_AXES), .SAFETY_COUNT(SAFETY_COUNT)) i_dut (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .reg_wen     (reg_wen),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_raddr   (reg_raddr),
        .reg_rdata   (reg_rdata),
        .board_id    (board_id),
        .cur_fb      (cur_fb),
        .cur_cmd     (cur_cmd),
        .dout        (dout),
        .amp_disable (amp_disable),
        .pwr_enable  (pwr_enable)
    );

    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", RUN_CYCLES);
        $display("Checks failed");
        $fatal(1);
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    function automatic reg_addr_t addr_of(input logic [3:0] space, input logic [3:0] chan,
                                          input logic [3:0] off);
        return {space, 4'h0, chan, off};
    endfunction

    // status read layout: amp 3..0, fault 7..4, pwr 16, id 27..24
    function automatic reg_data_t status_exp();
        reg_data_t w;
        w         = '0;
        w[3:0]    = exp_amp;
        w[7:4]    = exp_fault;
        w[16]     = exp_pwr;
        w[27:24]  = board_id;
        return w;
    endfunction

    // disables are the inverted enables, at port width
    function automatic logic [NUM_AXES-1:0] amp_off_exp();
        return ~exp_amp;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic check_outputs();
        for (int i = 0; i < NUM_AXES; i++)
            check_val($sformatf("cur_cmd[%0d]", i), cur_cmd[i], exp_cmd[i]);
        check_val("dout", dout, exp_dout);
        check_val("amp_disable", amp_disable, amp_off_exp());
        check_val("pwr_enable", pwr_enable, exp_pwr);
    endtask

    // write pulse, then one more cycle for decode + execute
    task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
        @(negedge sysclk);
        reg_wen   = 1'b1;
        reg_waddr = addr;
        reg_wdata = data;
        @(negedge sysclk);
        reg_wen   = 1'b0;
        @(negedge sysclk);
    endtask

    task automatic expect_read(input reg_addr_t addr, input reg_data_t exp, input string name);
        @(negedge sysclk);
        reg_raddr = addr;
        @(negedge sysclk);      // one cycle read latency
        check_val(name, reg_rdata, exp);
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic verify_reset_defaults();
        check_outputs();
        check_val("amp_disable", amp_disable, 4'hF);     // all disabled
        expect_read(addr_of(ADDR_MAIN, 4'd0, OFF_STATUS), {4'h0, board_id, 24'h0}, "status");
    endtask

    task automatic exercise_axis_regs();
        reg_data_t data;
        for (int i = 0; i < NUM_AXES; i++) begin
            data       = $random(seed);     // upper half must be ignored
            exp_cmd[i] = data[15:0];
            bus_write(addr_of(ADDR_MAIN, 4'(i + 1), OFF_DAC_CTRL), data);
            check_outputs();
            data        = $random(seed);
            exp_dout[i] = data[0];
            bus_write(addr_of(ADDR_MAIN, 4'(i + 1), OFF_DOUT_CTRL), data);
            check_outputs();
            data      = $random(seed);
            cur_fb[i] = data[15:0] & exp_cmd[i];    // stays within the trip limit
            expect_read(addr_of(ADDR_MAIN, 4'(i + 1), OFF_ADC_DATA), {16'h0, cur_fb[i]}, "adc");
            expect_read(addr_of(ADDR_MAIN, 4'(i + 1), OFF_DAC_CTRL), {16'h0, exp_cmd[i]}, "dac");
            expect_read(addr_of(ADDR_MAIN, 4'(i + 1), OFF_DOUT_CTRL), {31'h0, exp_dout[i]},
                        "dout_rd");
        end
        check_outputs();
    endtask

    task automatic apply_status_masks();
        reg_addr_t st;
        st = addr_of(ADDR_MAIN, 4'd0, OFF_STATUS);
        bus_write(st, 32'h000C_0505);   // amps 0,2 on, power on
        exp_amp = 4'b0101;
        exp_pwr = 1'b1;
        check_outputs();
        bus_write(st, 32'h0008_060A);   // amp 1 on, amp 2 and power off; value bit 3 unmasked
        exp_amp = 4'b0011;
        exp_pwr = 1'b0;
        check_outputs();
        expect_read(st, status_exp(), "status");
        // outside main space, unknown offsets: no effect
        bus_write(addr_of(4'h1, 4'd0, OFF_STATUS), 32'h0008_0F00);
        bus_write(addr_of(ADDR_MAIN, 4'd0, 4'h7), 32'h0008_0F00);
        bus_write(addr_of(ADDR_MAIN, 4'd1, 4'h5), $random(seed));
        bus_write(addr_of(4'h2, 4'd1, OFF_DAC_CTRL), $random(seed));
        check_outputs();
        expect_read(st, status_exp(), "status");
        expect_read(addr_of(ADDR_MAIN, 4'd0, OFF_BOARD_ID), {28'h0, board_id}, "board_id");
        expect_read(addr_of(4'h1, 4'd0, OFF_STATUS), 32'h0, "rdata_other_space");
        expect_read(addr_of(ADDR_MAIN, 4'd6, OFF_DAC_CTRL), 32'h0, "rdata_no_axis");
    endtask

    task automatic trip_safety();
        reg_data_t data;
        cur_fb[1] = '0;
        exp_cmd[1] = 16'd1000;          // limit is 2000
        bus_write(addr_of(ADDR_MAIN, 4'd2, OFF_DAC_CTRL), 32'd1000);
        // short excursion, back to the limit before the count completes
        @(negedge sysclk);
        cur_fb[1] = 16'd2001;
        repeat (SAFETY_COUNT - 1) @(negedge sysclk);
        cur_fb[1] = 16'd2000;
        repeat (SAFETY_COUNT + 4) begin
            @(negedge sysclk);
            check_val("amp_disable", amp_disable, amp_off_exp());
        end
        expect_read(addr_of(ADDR_MAIN, 4'd0, OFF_STATUS), status_exp(), "status");
        // sustained over-limit
        @(negedge sysclk);
        data      = $random(seed);
        cur_fb[1] = 16'd2001 + {2'b00, data[13:0]};
        repeat (SAFETY_COUNT + 1) begin
            @(negedge sysclk);
            check_val("amp_disable", amp_disable, amp_off_exp());
        end
        @(negedge sysclk);
        exp_amp[1]   = 1'b0;
        exp_fault[1] = 1'b1;
        check_outputs();
        expect_read(addr_of(ADDR_MAIN, 4'd0, OFF_STATUS), status_exp(), "status");
    endtask

    task automatic recover_from_fault();
        @(negedge sysclk);
        cur_fb[1] = 16'd2000;           // at the limit, not over
        bus_write(addr_of(ADDR_MAIN, 4'd0, OFF_STATUS), 32'h0000_0202);
        exp_amp[1]   = 1'b1;
        exp_fault[1] = 1'b0;
        check_outputs();
        expect_read(addr_of(ADDR_MAIN, 4'd0, OFF_STATUS), status_exp(), "status");
        repeat (SAFETY_COUNT + 2) @(negedge sysclk);
        check_outputs();                // no re-trip
        expect_read(addr_of(ADDR_MAIN, 4'd0, OFF_STATUS), status_exp(), "status");
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        seed      = 36;
        arst_n    = 1'b0;
        reg_wen   = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_raddr = '0;
        board_id  = 4'hA;
        exp_dout  = '0;
        exp_amp   = '0;
        exp_fault = '0;
        exp_pwr   = 1'b0;
        for (int i = 0; i < NUM_AXES; i++) begin
            cur_fb[i]  = '0;
            exp_cmd[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge sysclk);
        @(negedge sysclk);
        arst_n = 1'b1;

        verify_reset_defaults();
        exercise_axis_regs();
        apply_status_masks();
        trip_safety();
        recover_from_fault();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/axis_ctrl.sv */
/*
 * Execute stage for one motor axis.
 * Holds the current command and the digital output bit, and runs
 * the safety check: a fault latches once the feedback current stays
 * above twice the command for SAFETY_COUNT consecutive cycles.
 */

`default_nettype none

module axis_ctrl import qla_pkg::*; #(
    parameter int SAFETY_COUNT = 8
) (
    input  logic      sysclk,
    input  logic      arst_n,
    input  logic      dac_wen,
    input  logic      dout_wen,
    input  reg_data_t wdata,
    input  cur_t      cur_fb,
    input  logic      safety_clear,
    output cur_t      cur_cmd,
    output logic      dout,
    output logic      safety_fault
);

    localparam int CNT_W = $clog2(SAFETY_COUNT + 1);

    logic [16:0]      cmd_x2;       // 2 * cur_cmd, no overflow
    logic [16:0]      fb_ext;
    logic             over_limit;
    logic [CNT_W-1:0] over_cnt;     // consecutive over-limit cycles
    logic             cnt_done;

    // ------------------------------------------------------------------
    // command and output registers
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cur_cmd <= '0;
            dout    <= 1'b0;
        end else begin
            if (dac_wen)
                cur_cmd <= wdata[15:0];
            if (dout_wen)
                dout <= wdata[0];
        end
    end

    // ------------------------------------------------------------------
    // safety check
    // ------------------------------------------------------------------
    assign cmd_x2     = {cur_cmd, 1'b0};
    assign fb_ext     = {1'b0, cur_fb};
    assign over_limit = fb_ext > cmd_x2;    // equal to the limit is fine
    assign cnt_done   = (over_cnt == CNT_W'(SAFETY_COUNT));

    // counter saturates at SAFETY_COUNT, any good sample restarts it
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            over_cnt <= '0;
        end else if (safety_clear || !over_limit) begin
            over_cnt <= '0;
        end else if (!cnt_done) begin
            over_cnt <= over_cnt + 1'b1;
        end
    end

    // fault is sticky, only a clear from the board regs drops it
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            safety_fault <= 1'b0;
        end else if (safety_clear) begin
            safety_fault <= 1'b0;
        end else if (cnt_done) begin
            safety_fault <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/board_regs.sv */
/*
 * Channel 0 board registers.
 * Masked writes to the status register set the amplifier enables and
 * the power enable. Enabling an amplifier also clears its safety
 * fault; a newly raised fault drops that amplifier's enable.
 */

`default_nettype none

module board_regs import qla_pkg::*; #(
    parameter int NUM_AXES = 4
) (
    input  logic                sysclk,
    input  logic                arst_n,
    input  logic                status_wen,
    input  reg_data_t           wdata,
    input  logic [NUM_AXES-1:0] safety_fault,
    output logic [NUM_AXES-1:0] amp_en,
    output logic                pwr_enable,
    output logic [NUM_AXES-1:0] safety_clear
);

    logic [NUM_AXES-1:0] amp_mask;      // axes selected by this write
    logic [NUM_AXES-1:0] amp_val;
    logic [NUM_AXES-1:0] fault_q;       // previous fault, for edge detect
    logic [NUM_AXES-1:0] fault_rise;
    logic [NUM_AXES-1:0] amp_en_d;

    assign amp_mask   = status_wen ? wdata[STAT_AMP_MASK_LSB +: NUM_AXES] : '0;
    assign amp_val    = wdata[STAT_AMP_VAL_LSB +: NUM_AXES];
    assign fault_rise = safety_fault & ~fault_q;

    // enabling a masked axis clears its fault in the same cycle
    assign safety_clear = amp_mask & amp_val;

    // ------------------------------------------------------------------
    // amplifier enable next state
    // ------------------------------------------------------------------
    always_comb begin
        amp_en_d = amp_en;
        for (int i = 0; i < NUM_AXES; i++) begin
            if (fault_rise[i]) begin
                amp_en_d[i] = 1'b0;                 // trip wins over a write
            end else if (amp_mask[i]) begin
                amp_en_d[i] = amp_val[i];           // a set also clears the held fault
            end
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            amp_en  <= '0;
            fault_q <= '0;
        end else begin
            amp_en  <= amp_en_d;
            fault_q <= safety_fault;
        end
    end

    // power enable, same mask/value scheme
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pwr_enable <= 1'b0;
        end else if (status_wen && wdata[STAT_PWR_MASK]) begin
            pwr_enable <= wdata[STAT_PWR_VAL];
        end
    end

endmodule

`default_nettype wire

/* verilog/qla_ctrl.sv */
/*
 * Motor-axis controller core, top level.
 * Register bus write path: decode stage, then per-axis and board
 * execute stages. Read path: one registered result mux.
 * Feedback currents come in and command currents go out in parallel.
 */

`default_nettype none

module qla_ctrl import qla_pkg::*; #(
    parameter int NUM_AXES     = 4,     // 1..4
    parameter int SAFETY_COUNT = 8
) (
    input  logic                sysclk,
    input  logic                arst_n,
    // register bus
    input  logic                reg_wen,
    input  reg_addr_t           reg_waddr,
    input  reg_data_t           reg_wdata,
    input  reg_addr_t           reg_raddr,
    output reg_data_t           reg_rdata,
    // board and axis i/o
    input  field_t              board_id,       // rotary switch
    input  cur_t                cur_fb [NUM_AXES],
    output cur_t                cur_cmd [NUM_AXES],
    output logic [NUM_AXES-1:0] dout,
    output logic [NUM_AXES-1:0] amp_disable,
    output logic                pwr_enable
);

    logic [NUM_AXES-1:0] dac_wen;
    logic [NUM_AXES-1:0] dout_wen;
    logic                status_wen;
    reg_data_t           wdata_q;
    logic [NUM_AXES-1:0] safety_clear;
    logic [NUM_AXES-1:0] safety_fault;
    logic [NUM_AXES-1:0] amp_en;

    // ------------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------------
    reg_addr_decode #(.NUM_AXES(NUM_AXES)) i_decode (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .reg_wen    (reg_wen),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .dac_wen    (dac_wen),
        .dout_wen   (dout_wen),
        .status_wen (status_wen),
        .wdata_q    (wdata_q)
    );

    // ------------------------------------------------------------------
    // axes, chan 1..NUM_AXES map to index 0..NUM_AXES-1
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        axis_ctrl #(.SAFETY_COUNT(SAFETY_COUNT)) i_axis (
            .sysclk       (sysclk),
            .arst_n       (arst_n),
            .dac_wen      (dac_wen[i]),
            .dout_wen     (dout_wen[i]),
            .wdata        (wdata_q),
            .cur_fb       (cur_fb[i]),
            .safety_clear (safety_clear[i]),
            .cur_cmd      (cur_cmd[i]),
            .dout         (dout[i]),
            .safety_fault (safety_fault[i])
        );
    end

    // channel 0 board registers
    board_regs #(.NUM_AXES(NUM_AXES)) i_board (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .status_wen   (status_wen),
        .wdata        (wdata_q),
        .safety_fault (safety_fault),
        .amp_en       (amp_en),
        .pwr_enable   (pwr_enable),
        .safety_clear (safety_clear)
    );

    assign amp_disable = ~amp_en;   // amp driver input is active high disable

    // ------------------------------------------------------------------
    // read path
    // ------------------------------------------------------------------
    reg_read_mux #(.NUM_AXES(NUM_AXES)) i_rmux (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .reg_raddr    (reg_raddr),
        .cur_fb       (cur_fb),
        .cur_cmd      (cur_cmd),
        .dout         (dout),
        .amp_en       (amp_en),
        .safety_fault (safety_fault),
        .pwr_enable   (pwr_enable),
        .board_id     (board_id),
        .reg_rdata    (reg_rdata)
    );

endmodule

`default_nettype wire

/* verilog/qla_pkg.sv */
/*
 * Shared definitions for the QLA motor-axis controller core.
 * Bus and current types, register address fields, register offsets
 * and the bit positions used in the board status register.
 */

`default_nettype none

package qla_pkg;

    // ------------------------------------------------------------------
    // bus and payload types
    // ------------------------------------------------------------------
    typedef logic [15:0] reg_addr_t;    // space | unused | chan | offset
    typedef logic [31:0] reg_data_t;
    typedef logic [15:0] cur_t;         // unsigned current, cmd or fb
    typedef logic [3:0]  field_t;       // one 4-bit address field

    // address spaces, only main is decoded here
    localparam field_t ADDR_MAIN = 4'h0;

    // offsets within an axis channel (chan 1..4)
    localparam field_t OFF_ADC_DATA  = 4'd0;
    localparam field_t OFF_DAC_CTRL  = 4'd1;
    localparam field_t OFF_DOUT_CTRL = 4'd2;

    // offsets within channel 0
    localparam field_t OFF_STATUS   = 4'd0;
    localparam field_t OFF_BOARD_ID = 4'd1;

    // ------------------------------------------------------------------
    // board status bit positions
    // ------------------------------------------------------------------
    // write side: mask bit selects, value bit gives the new state
    localparam int STAT_PWR_MASK     = 19;
    localparam int STAT_PWR_VAL      = 18;
    localparam int STAT_AMP_MASK_LSB = 8;
    localparam int STAT_AMP_VAL_LSB  = 0;

    // read side layout
    localparam int STAT_RD_AMP_LSB   = 0;   // amp enables 3..0
    localparam int STAT_RD_FAULT_LSB = 4;   // safety faults 7..4
    localparam int STAT_RD_PWR       = 16;  // power enable
    localparam int STAT_RD_ID_LSB    = 24;  // board id 27..24

    // address field extraction
    function automatic field_t addr_space(reg_addr_t addr);
        return addr[15:12];
    endfunction

    function automatic field_t addr_chan(reg_addr_t addr);
        return addr[7:4];
    endfunction

    function automatic field_t addr_off(reg_addr_t addr);
        return addr[3:0];
    endfunction

endpackage

`default_nettype wire

/* verilog/reg_addr_decode.sv */
/*
 * Register write decode stage.
 * Splits a bus write into space, channel and offset and turns it
 * into one registered strobe: per-axis DAC or DOUT, or board status.
 * Write data is registered alongside the strobes.
 */

`default_nettype none

module reg_addr_decode import qla_pkg::*; #(
    parameter int NUM_AXES = 4
) (
    input  logic                sysclk,
    input  logic                arst_n,
    input  logic                reg_wen,
    input  reg_addr_t           reg_waddr,
    input  reg_data_t           reg_wdata,
    output logic [NUM_AXES-1:0] dac_wen,
    output logic [NUM_AXES-1:0] dout_wen,
    output logic                status_wen,
    output reg_data_t           wdata_q
);

    field_t              space;
    field_t              chan;
    field_t              offset;
    logic                main_hit;      // write lands in main space
    logic [NUM_AXES-1:0] dac_wen_d;
    logic [NUM_AXES-1:0] dout_wen_d;
    logic                status_wen_d;

    assign space    = addr_space(reg_waddr);
    assign chan     = addr_chan(reg_waddr);
    assign offset   = addr_off(reg_waddr);
    assign main_hit = reg_wen && (space == ADDR_MAIN);

    // channel 0 is the board, 1..NUM_AXES the axes
    always_comb begin
        dac_wen_d    = '0;
        dout_wen_d   = '0;
        status_wen_d = main_hit && (chan == 4'd0) && (offset == OFF_STATUS);
        for (int i = 0; i < NUM_AXES; i++) begin
            if (main_hit && (chan == field_t'(i + 1))) begin
                dac_wen_d[i]  = (offset == OFF_DAC_CTRL);
                dout_wen_d[i] = (offset == OFF_DOUT_CTRL);   // adc offset is read only
            end
        end
    end

    // ------------------------------------------------------------------
    // decode register
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            dac_wen    <= '0;
            dout_wen   <= '0;
            status_wen <= 1'b0;
        end else begin
            dac_wen    <= dac_wen_d;
            dout_wen   <= dout_wen_d;
            status_wen <= status_wen_d;
        end
    end

    always_ff @(posedge sysclk) begin
        if (reg_wen)
            wdata_q <= reg_wdata;   // held until the next write
    end

endmodule

`default_nettype wire

/* verilog/reg_read_mux.sv */
/*
 * Register read result stage.
 * Decodes the read address on its own, picks the axis or board value
 * and registers it onto reg_rdata. Unmapped addresses read as zero.
 */

`default_nettype none

module reg_read_mux import qla_pkg::*; #(
    parameter int NUM_AXES = 4
) (
    input  logic                sysclk,
    input  logic                arst_n,
    input  reg_addr_t           reg_raddr,
    input  cur_t                cur_fb [NUM_AXES],
    input  cur_t                cur_cmd [NUM_AXES],
    input  logic [NUM_AXES-1:0] dout,
    input  logic [NUM_AXES-1:0] amp_en,
    input  logic [NUM_AXES-1:0] safety_fault,
    input  logic                pwr_enable,
    input  field_t              board_id,
    output reg_data_t           reg_rdata
);

    field_t    space;
    field_t    chan;
    field_t    offset;
    reg_data_t status_word;
    reg_data_t rdata_d;

    assign space  = addr_space(reg_raddr);
    assign chan   = addr_chan(reg_raddr);
    assign offset = addr_off(reg_raddr);

    // status layout, unused axis bits stay zero
    always_comb begin
        status_word = '0;
        status_word[STAT_RD_AMP_LSB +: NUM_AXES]   = amp_en;
        status_word[STAT_RD_FAULT_LSB +: NUM_AXES] = safety_fault;
        status_word[STAT_RD_PWR]                   = pwr_enable;
        status_word[STAT_RD_ID_LSB +: 4]           = board_id;
    end

    // ------------------------------------------------------------------
    // read select
    // ------------------------------------------------------------------
    always_comb begin
        rdata_d = '0;
        if (space == ADDR_MAIN) begin
            if (chan == 4'd0) begin
                if (offset == OFF_STATUS)
                    rdata_d = status_word;
                else if (offset == OFF_BOARD_ID)
                    rdata_d[3:0] = board_id;
            end
            for (int i = 0; i < NUM_AXES; i++) begin
                if (chan == field_t'(i + 1)) begin
                    case (offset)
                        OFF_ADC_DATA:  rdata_d[15:0] = cur_fb[i];
                        OFF_DAC_CTRL:  rdata_d[15:0] = cur_cmd[i];
                        OFF_DOUT_CTRL: rdata_d[0]    = dout[i];
                        default:       rdata_d       = '0;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n)
            reg_rdata <= '0;
        else
            reg_rdata <= rdata_d;   // refreshed every cycle
    end

endmodule

`default_nettype wire
